/* verilog.f */
design/rx_frontend_pkg.sv
design/rx_settings_regs.sv
design/rx_iq_mapper.sv
design/rx_dc_offset.sv
design/rx_iq_balance.sv
design/rx_round_clip.sv
design/rx_frontend.sv
verification/rx_frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rx_frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rx_frontend_tb -f verilog.f -o sim_rx_frontend
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_rx_frontend
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

/* verification/rx_frontend_tb.sv */
module rx_frontend_tb
  import rx_frontend_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SR_BASE      = 16;
  localparam int ROW_CYCLES   = 40;
  localparam int BURST_CYCLES = 200;
  localparam int BURST_LEN    = 32;
  localparam int LATENCY      = 5;
  localparam int MAX_WAIT     = 20;

  // Register values as written on the bus plus one sample and its result
  typedef struct packed {
    logic [31:0] mag;
    logic [31:0] phase;
    logic [31:0] ofs_i;
    logic [31:0] ofs_q;
    logic [3:0]  map;
    sc16_t       din;
    sc16_t       exp;
  } row_t;

  logic        clk;
  logic        reset;
  set_bus_t    set_i;
  logic        adc_stb_i;
  sc16_t       adc_i;
  logic        rx_stb_o;
  sc16_t       rx_o;
  string       names[$];
  row_t        rows[$];
  sc16_t       expected_q[$];
  logic [15:0] lfsr;

  rx_frontend #(.SR_BASE(SR_BASE)) i_rx_frontend (
    .clk       (clk),
    .reset     (reset),
    .set_i     (set_i),
    .adc_stb_i (adc_stb_i),
    .adc_i     (adc_i),
    .rx_stb_o  (rx_stb_o),
    .rx_o      (rx_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation aborted");
  endtask

  task automatic check_sc16(input string name, input sc16_t exp, input sc16_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected i=%0d q=%0d actual i=%0d q=%0d",
               name, exp.i, exp.q, act.i, act.q);
      abort_run();
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act !== exp) begin
      $display("CHECK FAILED %s latency expected %0d actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_word();
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < 16; b++) begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic longint sat_signed(input longint x, input int w);
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (w - 1)) - 1;
    lo = -(longint'(1) <<< (w - 1));
    return (x > hi) ? hi : ((x < lo) ? lo : x);
  endfunction

  // Reference model that maps, widens, subtracts the offset, balances and rounds half up
  function automatic sc16_t model_sample(input row_t r);
    longint si;
    longint sq;
    longint ri;
    longint rq;
    longint mag;
    longint phase;
    longint oi;
    longint oq;
    longint wi;
    longint wq;
    longint t;
    sc16_t  res;
    si    = r.din.i;
    sq    = r.din.q;
    mag   = longint'($signed(r.mag[CORR_W-1:0]));
    phase = longint'($signed(r.phase[CORR_W-1:0]));
    oi    = longint'($signed(r.ofs_i[IQ_W-1:0]));
    oq    = longint'($signed(r.ofs_q[IQ_W-1:0]));
    // Complement of a 16-bit value is -x-1
    if (r.map[0]) begin
      ri = r.map[2] ? -sq - 1 : sq;
      rq = r.map[3] ? -si - 1 : si;
    end else begin
      ri = r.map[3] ? -si - 1 : si;
      rq = r.map[2] ? -sq - 1 : sq;
    end
    if (r.map[1]) begin
      rq = 0;
    end
    wi  = sat_signed(ri * 256 - oi, IQ_W);
    wq  = sat_signed(rq * 256 - oq, IQ_W);
    t   = wi >>> 6;
    wi  = sat_signed(wi + ((t * mag) >>> 11), IQ_W);
    wq  = sat_signed(wq + ((t * phase) >>> 11), IQ_W);
    res.i = 16'(sat_signed((wi + 128) >>> 8, OUT_W));
    res.q = 16'(sat_signed((wq + 128) >>> 8, OUT_W));
    return res;
  endfunction

  task automatic add_row(input string name, input int mag, input int phase,
                         input int ofs_i, input int ofs_q, input logic [3:0] map,
                         input int in_i, input int in_q, input int ex_i, input int ex_q);
    row_t r;
    r.mag   = mag;
    r.phase = phase;
    r.ofs_i = ofs_i;
    r.ofs_q = ofs_q;
    r.map   = map;
    r.din.i = 16'(in_i);
    r.din.q = 16'(in_q);
    r.exp.i = 16'(ex_i);
    r.exp.q = 16'(ex_q);
    names.push_back(name);
    rows.push_back(r);
  endtask

  // Expected values computed by hand
  // Map bits from bit 3 down are invert_i invert_q realmode swap
  task automatic build_table();
    add_row("identity",        0,      0,        0,       0,       4'h0, 1000,  -2000, 1000,  -2000);
    add_row("identity_ext",    0,      0,        0,       0,       4'h0, 32767, -32768, 32767, -32768);
    add_row("swap",            0,      0,        0,       0,       4'h1, 100,   -200,  -200,  100);
    add_row("invert_i",        0,      0,        0,       0,       4'h8, 100,   -200,  -101,  -200);
    add_row("invert_q",        0,      0,        0,       0,       4'h4, 100,   -200,  100,   199);
    add_row("swap_invert_q",   0,      0,        0,       0,       4'h5, 100,   -200,  199,   100);
    add_row("realmode",        0,      0,        0,       0,       4'h2, 300,   400,   300,   0);
    add_row("offset_256",      0,      0,        256,     -512,    4'h0, 10,    10,    9,     12);
    add_row("offset_sat",      0,      0,        -8388608, 8388607, 4'h0, 20000, -20000, 32767, -32768);
    add_row("mag_half",        65536,  0,        0,       0,       4'h0, 1000,  0,     1500,  0);
    add_row("phase_pos",       0,      13107,    0,       0,       4'h0, 1000,  500,   1000,  600);
    add_row("phase_neg",       0,      -26214,   0,       0,       4'h0, -1000, 0,     -1000, 200);
    add_row("mag_clip",        131071, 0,        0,       0,       4'h0, 30000, 5,     32767, 5);
    add_row("round_half_up",   0,      0,        128,     384,     4'h0, 1,     -1,    1,     -2);
  endtask

  task automatic write_reg(input int offset, input logic [31:0] value);
    @(posedge clk);
    set_i <= '{stb: 1'b1, addr: 8'(SR_BASE + offset), data: value};
  endtask

  task automatic apply_config(input row_t r);
    write_reg(REG_MAG, r.mag);
    write_reg(REG_PHASE, r.phase);
    write_reg(REG_OFS_I, r.ofs_i);
    write_reg(REG_OFS_Q, r.ofs_q);
    write_reg(REG_MAP, {28'd0, r.map});
    @(posedge clk);
    set_i <= '0;
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   lat;
    r = rows[idx];
    apply_config(r);
    @(posedge clk);
    adc_stb_i <= 1'b1;
    adc_i     <= r.din;
    @(posedge clk);
    adc_stb_i <= 1'b0;
    // Count cycles from the edge that took the strobe to the output strobe
    lat = 1;
    @(negedge clk);
    while (!rx_stb_o && lat < MAX_WAIT) begin
      lat++;
      @(negedge clk);
    end
    if (!rx_stb_o) begin
      $display("No output strobe seen for row %s within %0d cycles", names[idx], MAX_WAIT);
      abort_run();
    end else begin
      check_latency(names[idx], LATENCY, lat);
      check_sc16(names[idx], r.exp, rx_o);
    end
  endtask

  task automatic run_burst();
    row_t  r;
    sc16_t s;
    int    got_n;
    r       = '0;
    r.mag   = 6554;
    r.phase = -3277;
    r.ofs_i = 1000;
    r.ofs_q = -700;
    r.map   = 4'h5;
    got_n   = 0;
    apply_config(r);
    fork
      begin
        for (int n = 0; n < BURST_LEN; n++) begin
          s.i   = rand_word();
          s.q   = rand_word();
          r.din = s;
          expected_q.push_back(model_sample(r));
          @(posedge clk);
          adc_stb_i <= 1'b1;
          adc_i     <= s;
        end
        @(posedge clk);
        adc_stb_i <= 1'b0;
      end
      begin
        repeat (BURST_LEN) begin
          @(negedge clk);
          while (!rx_stb_o) @(negedge clk);
          check_sc16($sformatf("burst_%0d", got_n), expected_q.pop_front(), rx_o);
          got_n++;
        end
      end
    join
  endtask

  // Budget grows with the table length
  initial begin
    @(negedge reset);
    repeat (rows.size() * ROW_CYCLES + BURST_CYCLES) @(posedge clk);
    $display("Timed out: the run did not finish in the allowed number of cycles");
    abort_run();
  end

  initial begin
    reset     = 1'b1;
    set_i     = '0;
    adc_stb_i = 1'b0;
    adc_i     = '0;
    lfsr      = 16'd25133;
    build_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (int k = 0; k < rows.size(); k++) begin
      run_row(k);
    end
    run_burst();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* design/rx_frontend.sv */
module rx_frontend
  import rx_frontend_pkg::*;
#(
  parameter int SR_BASE          = 0,
  parameter bit BYPASS_DC_OFFSET = 1'b0,
  parameter bit BYPASS_IQ_COMP   = 1'b0
) (
  input  logic     clk,
  input  logic     reset,
  input  set_bus_t set_i,
  input  logic     adc_stb_i,
  input  sc16_t    adc_i,
  output logic     rx_stb_o,
  output sc16_t    rx_o
);

  rx_config_t cfg;
  logic       map_stb;
  iq24_t      map_data;
  logic       ofs_stb;
  iq24_t      ofs_data;
  logic       comp_stb;
  iq24_t      comp_data;

  rx_settings_regs #(.SR_BASE(SR_BASE)) i_rx_settings_regs (
    .clk   (clk),
    .reset (reset),
    .set_i (set_i),
    .cfg_o (cfg)
  );

  rx_iq_mapper i_rx_iq_mapper (
    .clk    (clk),
    .reset  (reset),
    .cfg_i  (cfg),
    .stb_i  (adc_stb_i),
    .data_i (adc_i),
    .stb_o  (map_stb),
    .data_o (map_data)
  );

  generate
    if (!BYPASS_DC_OFFSET) begin : g_dc_offset
      rx_dc_offset i_rx_dc_offset (
        .clk    (clk),
        .reset  (reset),
        .cfg_i  (cfg),
        .stb_i  (map_stb),
        .data_i (map_data),
        .stb_o  (ofs_stb),
        .data_o (ofs_data)
      );
    end else begin : g_dc_bypass
      assign ofs_stb  = map_stb;
      assign ofs_data = map_data;
    end
  endgenerate

  generate
    if (!BYPASS_IQ_COMP) begin : g_iq_balance
      rx_iq_balance i_rx_iq_balance (
        .clk    (clk),
        .reset  (reset),
        .cfg_i  (cfg),
        .stb_i  (ofs_stb),
        .data_i (ofs_data),
        .stb_o  (comp_stb),
        .data_o (comp_data)
      );
    end else begin : g_iq_bypass
      assign comp_stb  = ofs_stb;
      assign comp_data = ofs_data;
    end
  endgenerate

  rx_round_clip i_rx_round_clip (
    .clk    (clk),
    .reset  (reset),
    .stb_i  (comp_stb),
    .data_i (comp_data),
    .stb_o  (rx_stb_o),
    .data_o (rx_o)
  );

endmodule

/* design/rx_round_clip.sv */
module rx_round_clip
  import rx_frontend_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  stb_i,
  input  iq24_t data_i,
  output logic  stb_o,
  output sc16_t data_o
);

  localparam int ROUND_SHIFT = IQ_W - OUT_W;
  localparam logic signed [31:0] HALF_LSB = 32'sd1 <<< (ROUND_SHIFT - 1);

  logic signed [31:0] rnd_i;
  logic signed [31:0] rnd_q;
  logic signed [31:0] sat_i;
  logic signed [31:0] sat_q;

  // Round half up, floor shift, then saturate to sc16
  always_comb begin
    rnd_i = (data_i.i + HALF_LSB) >>> ROUND_SHIFT;
    rnd_q = (data_i.q + HALF_LSB) >>> ROUND_SHIFT;
    sat_i = clip_to(rnd_i, OUT_W);
    sat_q = clip_to(rnd_q, OUT_W);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      data_o.i <= sat_i[OUT_W-1:0];
      data_o.q <= sat_q[OUT_W-1:0];
    end
  end

endmodule

/* design/rx_iq_balance.sv */
module rx_iq_balance
  import rx_frontend_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  rx_config_t cfg_i,
  input  logic       stb_i,
  input  iq24_t      data_i,
  output logic       stb_o,
  output iq24_t      data_o
);

  // Shift the product back to the 24-bit rail scale
  localparam int PROD_W     = 2 * CORR_W;
  localparam int PROD_SHIFT = 11;

  logic [1:0]               stb_sr;
  logic signed [CORR_W-1:0] top_i;
  logic signed [PROD_W-1:0] prod_mag;
  logic signed [PROD_W-1:0] prod_phase;
  iq24_t                    data_d1;
  logic signed [31:0]       term_mag;
  logic signed [31:0]       term_phase;
  logic signed [31:0]       sum_i;
  logic signed [31:0]       sum_q;

  // Top 18 bits of I feed both multipliers
  assign top_i = data_i.i[IQ_W-1 -: CORR_W];

  // Stage 1 multiplies while the raw sample rides alongside
  always_ff @(posedge clk) begin
    if (stb_i) begin
      prod_mag   <= top_i * cfg_i.mag_corr;
      prod_phase <= top_i * cfg_i.phase_corr;
      data_d1    <= data_i;
    end
  end

  // Arithmetic shift gives the floor
  always_comb begin
    term_mag   = 32'(prod_mag >>> PROD_SHIFT);
    term_phase = 32'(prod_phase >>> PROD_SHIFT);
    sum_i      = clip_to(data_d1.i + term_mag, IQ_W);
    sum_q      = clip_to(data_d1.q + term_phase, IQ_W);
  end

  // Stage 2 adds and clips
  always_ff @(posedge clk) begin
    if (stb_sr[0]) begin
      data_o.i <= sum_i[IQ_W-1:0];
      data_o.q <= sum_q[IQ_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_sr <= 2'b00;
    end else begin
      stb_sr <= {stb_sr[0], stb_i};
    end
  end

  assign stb_o = stb_sr[1];

  // Valid output data never carries unknown bits
  a_data_known: assert property (@(posedge clk) disable iff (reset)
    stb_o |-> !$isunknown(data_o));

endmodule

/* design/rx_dc_offset.sv */
module rx_dc_offset
  import rx_frontend_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  rx_config_t cfg_i,
  input  logic       stb_i,
  input  iq24_t      data_i,
  output logic       stb_o,
  output iq24_t      data_o
);

  logic signed [31:0] diff_i;
  logic signed [31:0] diff_q;
  logic signed [31:0] sat_i;
  logic signed [31:0] sat_q;

  // Both operands are sign extended before the subtract
  always_comb begin
    diff_i = data_i.i - cfg_i.offset_i;
    diff_q = data_i.q - cfg_i.offset_q;
    sat_i  = clip_to(diff_i, IQ_W);
    sat_q  = clip_to(diff_q, IQ_W);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      data_o.i <= sat_i[IQ_W-1:0];
      data_o.q <= sat_q[IQ_W-1:0];
    end
  end

  // An X strobe here would poison every later stage
  a_stb_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(stb_o));

endmodule

/* design/rx_iq_mapper.sv */
module rx_iq_mapper
  import rx_frontend_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  rx_config_t cfg_i,
  input  logic       stb_i,
  input  sc16_t      data_i,
  output logic       stb_o,
  output iq24_t      data_o
);

  localparam int PAD_W = IQ_W - OUT_W;

  logic [OUT_W-1:0] rail_i;
  logic [OUT_W-1:0] rail_q;

  // Rail selection, then complement where asked
  always_comb begin
    if (cfg_i.map.swap_iq) begin
      rail_i = cfg_i.map.invert_q ? ~data_i.q : data_i.q;
      rail_q = cfg_i.map.invert_i ? ~data_i.i : data_i.i;
    end else begin
      rail_i = cfg_i.map.invert_i ? ~data_i.i : data_i.i;
      rail_q = cfg_i.map.invert_q ? ~data_i.q : data_i.q;
    end
    // Real mode keeps only the I rail
    if (cfg_i.map.realmode) begin
      rail_q = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  // Widen into the upper bits, zero fraction below
  always_ff @(posedge clk) begin
    if (stb_i) begin
      data_o.i <= {rail_i, {PAD_W{1'b0}}};
      data_o.q <= {rail_q, {PAD_W{1'b0}}};
    end
  end

endmodule

/* design/rx_settings_regs.sv */
module rx_settings_regs
  import rx_frontend_pkg::*;
#(
  parameter int SR_BASE = 0
) (
  input  logic       clk,
  input  logic       reset,
  input  set_bus_t   set_i,
  output rx_config_t cfg_o
);

  logic       hit_mag;
  logic       hit_phase;
  logic       hit_ofs_i;
  logic       hit_ofs_q;
  logic       hit_map;
  rx_config_t cfg_q;

  // Address decode for the five registers
  assign hit_mag   = set_i.stb && (set_i.addr == 8'(SR_BASE + REG_MAG));
  assign hit_phase = set_i.stb && (set_i.addr == 8'(SR_BASE + REG_PHASE));
  assign hit_ofs_i = set_i.stb && (set_i.addr == 8'(SR_BASE + REG_OFS_I));
  assign hit_ofs_q = set_i.stb && (set_i.addr == 8'(SR_BASE + REG_OFS_Q));
  assign hit_map   = set_i.stb && (set_i.addr == 8'(SR_BASE + REG_MAP));

  // All zero means identity correction and straight mapping
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_q <= '0;
    end else begin
      if (hit_mag) begin
        cfg_q.mag_corr <= set_i.data[CORR_W-1:0];
      end
      if (hit_phase) begin
        cfg_q.phase_corr <= set_i.data[CORR_W-1:0];
      end
      if (hit_ofs_i) begin
        cfg_q.offset_i <= set_i.data[IQ_W-1:0];
      end
      if (hit_ofs_q) begin
        cfg_q.offset_q <= set_i.data[IQ_W-1:0];
      end
      if (hit_map) begin
        cfg_q.map <= set_i.data[3:0];
      end
    end
  end

  assign cfg_o = cfg_q;

  // An unknown write strobe would corrupt the configuration registers
  a_stb_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(set_i.stb));

endmodule

/* design/rx_frontend_pkg.sv */
package rx_frontend_pkg;

  // Rail widths and coefficient format
  localparam int IQ_W   = 24;
  localparam int OUT_W  = 16;
  // Q1.17 signed
  localparam int CORR_W = 18;

  // Register offsets, added to SR_BASE
  localparam int REG_MAG   = 0;
  localparam int REG_PHASE = 1;
  localparam int REG_OFS_I = 2;
  localparam int REG_OFS_Q = 3;
  localparam int REG_MAP   = 4;

  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  // Field order matches bits 3..0 of the mapping register
  typedef struct packed {
    logic invert_i;
    logic invert_q;
    logic realmode;
    logic swap_iq;
  } iq_map_t;

  typedef struct packed {
    iq_map_t                  map;
    logic signed [CORR_W-1:0] mag_corr;
    logic signed [CORR_W-1:0] phase_corr;
    logic signed [IQ_W-1:0]   offset_i;
    logic signed [IQ_W-1:0]   offset_q;
  } rx_config_t;

  typedef struct packed {
    logic signed [IQ_W-1:0] i;
    logic signed [IQ_W-1:0] q;
  } iq24_t;

  typedef struct packed {
    logic signed [OUT_W-1:0] i;
    logic signed [OUT_W-1:0] q;
  } sc16_t;

  // Saturate a signed value to a w-bit signed range, result in the low w bits
  function automatic logic signed [31:0] clip_to(input logic signed [31:0] x,
                                                 input int unsigned w);
    logic signed [31:0] hi;
    logic signed [31:0] lo;
    hi = (32'sd1 <<< (w - 1)) - 32'sd1;
    lo = -(32'sd1 <<< (w - 1));
    if (x > hi) begin
      return hi;
    end
    if (x < lo) begin
      return lo;
    end
    return x;
  endfunction

endpackage
